/* design/pixel_block_buffer.sv */
//**************************************************************************
// FWFT pixel store; a block is offered only after its last word is written
// Writes while o_wr_full is high are dropped without notice
//**************************************************************************

`timescale 1ns/1ps

`include "pixel_stream_cfg.svh"

module pixel_block_buffer
  import pixel_stream_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_wr_stb,
  input  pix_word_t             i_wr_data,
  output logic                  o_wr_full,
  read_port_if.buffer_mp        rd
);

  localparam int PTR_W  = $clog2(`PS_BUF_DEPTH);
  localparam int CNT_W  = PTR_W + 1;
  localparam int LPTR_W = $clog2(`PS_LEN_DEPTH);
  localparam int LCNT_W = LPTR_W + 1;

  // Pixel store
  pix_word_t             mem [`PS_BUF_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      word_cnt;

  // Committed block lengths
  logic [`PS_SIZE_W-1:0] len_mem [`PS_LEN_DEPTH];
  logic [LPTR_W-1:0]     len_wr_ptr;
  logic [LPTR_W-1:0]     len_rd_ptr;
  logic [LCNT_W-1:0]     len_cnt;

  // Words written so far into the block still open
  logic [`PS_SIZE_W-1:0] open_len;

  logic                  act_q;
  logic                  wr_en;
  logic                  rd_en;
  logic                  len_push;
  logic                  len_pop;

  assign o_wr_full = (word_cnt == CNT_W'(`PS_BUF_DEPTH)) ||
                     (len_cnt == LCNT_W'(`PS_LEN_DEPTH));

  assign wr_en    = i_wr_stb && !o_wr_full;
  assign rd_en    = rd.read_stb && (word_cnt != '0);
  assign len_push = wr_en && i_wr_data.last;
  // Transaction ends on the falling edge of read_act
  assign len_pop  = act_q && !rd.read_act;

  // Read side, head word shown ahead of the strobe
  assign rd.read_rdy  = (len_cnt != '0);
  assign rd.read_size = len_mem[len_rd_ptr];
  assign rd.read_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_wr_data;
    end
    if (len_push) begin
      len_mem[len_wr_ptr] <= open_len + `PS_SIZE_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      word_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({wr_en, rd_en})
        2'b10:   word_cnt <= word_cnt + CNT_W'(1);
        2'b01:   word_cnt <= word_cnt - CNT_W'(1);
        default: word_cnt <= word_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      open_len   <= '0;
      len_wr_ptr <= '0;
      len_rd_ptr <= '0;
      len_cnt    <= '0;
      act_q      <= 1'b0;
    end else begin
      act_q <= rd.read_act;
      if (len_push) begin
        open_len   <= '0;
        len_wr_ptr <= len_wr_ptr + LPTR_W'(1);
      end else if (wr_en) begin
        open_len <= open_len + `PS_SIZE_W'(1);
      end
      if (len_pop) begin
        len_rd_ptr <= len_rd_ptr + LPTR_W'(1);
      end
      case ({len_push, len_pop})
        2'b10:   len_cnt <= len_cnt + LCNT_W'(1);
        2'b01:   len_cnt <= len_cnt - LCNT_W'(1);
        default: len_cnt <= len_cnt;
      endcase
    end
  end

endmodule

/* design/pixel_reader.sv */
//**************************************************************************
// Drains one committed block per transaction, one word per pixel strobe
// Outputs hold between strobes; test-pattern inputs force a channel to ones
//**************************************************************************

`timescale 1ns/1ps

`include "pixel_stream_cfg.svh"

module pixel_reader
  import pixel_stream_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  read_port_if.reader_mp         rd,
  input  logic                   i_pixel_stb,
  input  logic                   i_tp_red,
  input  logic                   i_tp_green,
  input  logic                   i_tp_blue,
  output logic [`PS_COLOR_W-1:0] o_red,
  output logic [`PS_COLOR_W-1:0] o_green,
  output logic [`PS_COLOR_W-1:0] o_blue,
  output logic                   o_last,
  output logic                   o_pixel_vld,
  output logic                   o_busy
);

  reader_state_e         state;
  logic                  act;
  logic                  pixel_rdy;
  logic [`PS_SIZE_W-1:0] remaining;

  assign rd.read_act = act;
  assign o_busy      = act;

  // Pops the head word; remaining guards against overrun
  assign rd.read_stb = pixel_rdy && i_pixel_stb && (remaining != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= READER_IDLE;
      act       <= 1'b0;
      pixel_rdy <= 1'b0;
      remaining <= '0;
    end else begin
      pixel_rdy <= act;
      case (state)
        READER_IDLE: begin
          if (rd.read_rdy) begin
            state     <= READER_ACTIVE;
            act       <= 1'b1;
            remaining <= rd.read_size;
          end
        end
        READER_ACTIVE: begin
          if (rd.read_stb) begin
            remaining <= remaining - `PS_SIZE_W'(1);
          end
          // Drop act once the count is spent, idle a cycle later
          if (act && remaining == '0) begin
            act <= 1'b0;
          end
          if (!act) begin
            state <= READER_IDLE;
          end
        end
        default: begin
          state <= READER_IDLE;
          act   <= 1'b0;
        end
      endcase
    end
  end

  // Output capture register
  always_ff @(posedge clk) begin
    if (rst) begin
      o_red       <= '0;
      o_green     <= '0;
      o_blue      <= '0;
      o_last      <= 1'b0;
      o_pixel_vld <= 1'b0;
    end else begin
      o_pixel_vld <= rd.read_stb;
      if (rd.read_stb) begin
        o_red   <= i_tp_red   ? '1 : rd.read_data.red;
        o_green <= i_tp_green ? '1 : rd.read_data.green;
        o_blue  <= i_tp_blue  ? '1 : rd.read_data.blue;
        o_last  <= rd.read_data.last;
      end
    end
  end

endmodule

/* design/pixel_stream_pkg.sv */
//**************************************************************************
// Shared types of the pixel path; widths come from the cfg header
//**************************************************************************

`include "pixel_stream_cfg.svh"

package pixel_stream_pkg;

  // One stored pixel word, last flag on top
  // Bit 24 is last, then red, green and blue down to bit 0
  typedef struct packed {
    logic                   last;
    logic [`PS_COLOR_W-1:0] red;
    logic [`PS_COLOR_W-1:0] green;
    logic [`PS_COLOR_W-1:0] blue;
  } pix_word_t;

  // Reader transaction states
  // ACTIVE covers the whole transfer plus the single
  // cycle after read_act has dropped
  typedef enum logic {
    READER_IDLE,
    READER_ACTIVE
  } reader_state_e;

endpackage

/* design/pixel_stream_top.sv */
//**************************************************************************
// Pixel path top; producer keeps each block within PS_BUF_DEPTH words
//**************************************************************************

`timescale 1ns/1ps

`include "pixel_stream_cfg.svh"

module pixel_stream_top
  import pixel_stream_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // Producer side
  input  logic                   i_wr_stb,
  input  logic [`PS_COLOR_W-1:0] i_wr_red,
  input  logic [`PS_COLOR_W-1:0] i_wr_green,
  input  logic [`PS_COLOR_W-1:0] i_wr_blue,
  input  logic                   i_wr_last,
  output logic                   o_wr_full,
  // Sink side
  input  logic                   i_sink_en,
  input  logic                   i_tp_red,
  input  logic                   i_tp_green,
  input  logic                   i_tp_blue,
  output logic [`PS_COLOR_W-1:0] o_red,
  output logic [`PS_COLOR_W-1:0] o_green,
  output logic [`PS_COLOR_W-1:0] o_blue,
  output logic                   o_last,
  output logic                   o_pixel_vld,
  output logic                   o_busy
);

  pix_word_t wr_word;
  logic      pixel_stb;

  read_port_if rd_if ();

  assign wr_word.last  = i_wr_last;
  assign wr_word.red   = i_wr_red;
  assign wr_word.green = i_wr_green;
  assign wr_word.blue  = i_wr_blue;

  pixel_block_buffer buffer_i (
    .clk       (clk),
    .rst       (rst),
    .i_wr_stb  (i_wr_stb),
    .i_wr_data (wr_word),
    .o_wr_full (o_wr_full),
    .rd        (rd_if.buffer_mp)
  );

  pixel_strobe_gen strobe_i (
    .clk         (clk),
    .rst         (rst),
    .i_sink_en   (i_sink_en),
    .o_pixel_stb (pixel_stb)
  );

  pixel_reader reader_i (
    .clk         (clk),
    .rst         (rst),
    .rd          (rd_if.reader_mp),
    .i_pixel_stb (pixel_stb),
    .i_tp_red    (i_tp_red),
    .i_tp_green  (i_tp_green),
    .i_tp_blue   (i_tp_blue),
    .o_red       (o_red),
    .o_green     (o_green),
    .o_blue      (o_blue),
    .o_last      (o_last),
    .o_pixel_vld (o_pixel_vld),
    .o_busy      (o_busy)
  );

endmodule

/* design/pixel_strobe_gen.sv */
//**************************************************************************
// One-cycle strobe every PS_PIX_DIV enabled cycles; count holds when stalled
//**************************************************************************

`timescale 1ns/1ps

`include "pixel_stream_cfg.svh"

module pixel_strobe_gen (
  input  logic clk,
  input  logic rst,
  input  logic i_sink_en,
  output logic o_pixel_stb
);

  localparam int CNT_W = (`PS_PIX_DIV > 1) ? $clog2(`PS_PIX_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`PS_PIX_DIV - 1);

  logic [CNT_W-1:0] div_cnt;

  // Strobe on the wrap cycle, only while the sink takes pixels
  assign o_pixel_stb = i_sink_en && (div_cnt == CNT_MAX);

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else if (i_sink_en) begin
      if (div_cnt == CNT_MAX) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + CNT_W'(1);
      end
    end
  end

endmodule

/* design/read_port_if.sv */
//**************************************************************************
// Block read port; read_size must hold while read_act is high
//**************************************************************************

`timescale 1ns/1ps

`include "pixel_stream_cfg.svh"

interface read_port_if
  import pixel_stream_pkg::*;
();

  // Driven by the block buffer
  logic                  read_rdy;
  logic [`PS_SIZE_W-1:0] read_size;
  pix_word_t             read_data;

  // Driven by the reader
  logic                  read_act;
  logic                  read_stb;

  modport buffer_mp (
    output read_rdy,
    output read_size,
    output read_data,
    input  read_act,
    input  read_stb
  );

  modport reader_mp (
    input  read_rdy,
    input  read_size,
    input  read_data,
    output read_act,
    output read_stb
  );

endinterface

/* include/pixel_stream_cfg.svh */
//**************************************************************************
// Buffer and length-queue depths must be powers of two; pointers wrap freely
// Blocks longer than PS_BUF_DEPTH never commit and stall the producer
//**************************************************************************

`ifndef PIXEL_STREAM_CFG_SVH
`define PIXEL_STREAM_CFG_SVH

// Width of one colour channel
`define PS_COLOR_W 8

// Width of a block size and of the reader's remaining count
`define PS_SIZE_W 24

// Pixel words held in the block buffer
`define PS_BUF_DEPTH 64

// Committed block lengths that can wait in the queue
`define PS_LEN_DEPTH 8

// clk cycles per pixel strobe
`define PS_PIX_DIV 4

`endif

/* pixel_stream_top.f */
+incdir+include
design/pixel_stream_pkg.sv
design/read_port_if.sv
design/pixel_block_buffer.sv
design/pixel_reader.sv
design/pixel_strobe_gen.sv
design/pixel_stream_top.sv
verification/pixel_stream_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the pixel stream testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f pixel_stream_top.f \
  --top-module pixel_stream_tb \
  -o sim_pixel_stream

./obj_dir/sim_pixel_stream | tee "$LOG"

if grep -qx "=== PASS ===" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* verification/pixel_stream_tb.sv */
//**************************************************************************
// Scoreboard samples on the rising edge; stimulus changes on the falling one
//**************************************************************************

`timescale 1ns/1ps

`include "pixel_stream_cfg.svh"

module pixel_stream_tb
  import pixel_stream_pkg::*;
();

  localparam int TIMEOUT = 4000;
  localparam logic [`PS_COLOR_W-1:0] FULL_SCALE = '1;

  logic                   clk;
  logic                   rst;
  logic                   i_wr_stb;
  logic                   i_wr_last;
  logic                   i_sink_en;
  logic                   i_tp_red, i_tp_green, i_tp_blue;
  logic [`PS_COLOR_W-1:0] i_wr_red, i_wr_green, i_wr_blue;
  logic [`PS_COLOR_W-1:0] o_red, o_green, o_blue;
  logic                   o_wr_full, o_last, o_pixel_vld, o_busy;

  pix_word_t              model_q[$];
  integer                 seed;
  int                     err_cnt = 0;
  int                     test_cnt = 0;
  int                     pix_cnt = 0;
  int                     cycle = 0;
  int                     last_vld_cycle = -1000;
  logic [2:0]             tp_q;
  logic                   sink_q;
  pix_word_t              out_q;

  pixel_stream_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic show_mismatch(input string name, input int got, input int expected);
    $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, expected);
    err_cnt++;
  endtask

  task automatic show_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_cnt++;
  endtask

  // Scoreboard, pacing and stall checks
  always @(posedge clk) begin
    pix_word_t want;
    pix_word_t wr;
    cycle++;
    if (!rst && o_pixel_vld) begin
      pix_cnt++;
      assert (cycle - last_vld_cycle >= `PS_PIX_DIV)
        else show_error("two pixels closer than the strobe period");
      last_vld_cycle = cycle;
      if (model_q.size() == 0) begin
        show_error("pixel came out with no written pixel left to match");
      end else begin
        want = model_q.pop_front();
        // Test pattern in force when the pixel was captured
        if (tp_q[2]) want.red = FULL_SCALE;
        if (tp_q[1]) want.green = FULL_SCALE;
        if (tp_q[0]) want.blue = FULL_SCALE;
        assert (o_red == want.red) else show_mismatch("o_red", int'(o_red), int'(want.red));
        assert (o_green == want.green)
          else show_mismatch("o_green", int'(o_green), int'(want.green));
        assert (o_blue == want.blue) else show_mismatch("o_blue", int'(o_blue), int'(want.blue));
        assert (o_last == want.last) else show_mismatch("o_last", int'(o_last), int'(want.last));
      end
    end
    // Sink low one cycle earlier means nothing may have moved
    if (!rst && !sink_q) begin
      assert (!o_pixel_vld) else show_mismatch("o_pixel_vld", int'(o_pixel_vld), 0);
      assert ({o_last, o_red, o_green, o_blue} == out_q)
        else show_error("outputs changed while the sink was stalled");
    end
    if (!rst && i_wr_stb && !o_wr_full) begin
      wr = '{last: i_wr_last, red: i_wr_red, green: i_wr_green, blue: i_wr_blue};
      model_q.push_back(wr);
    end
    tp_q   = {i_tp_red, i_tp_green, i_tp_blue};
    sink_q = i_sink_en;
    out_q  = {o_last, o_red, o_green, o_blue};
  end

  // Called on a falling edge; returns one falling edge after the write
  task automatic write_pixel(input pix_word_t w, input bit wait_space);
    int cnt;
    cnt = 0;
    while (wait_space && o_wr_full && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (wait_space && o_wr_full) begin
      show_error("timeout waiting for buffer space");
    end
    i_wr_stb   = 1'b1;
    i_wr_last  = w.last;
    i_wr_red   = w.red;
    i_wr_green = w.green;
    i_wr_blue  = w.blue;
    @(negedge clk);
    i_wr_stb = 1'b0;
  endtask

  task automatic write_block(input int len, input bit with_last);
    pix_word_t   w;
    logic [31:0] rnd;
    for (int i = 0; i < len; i++) begin
      rnd     = $random(seed);
      w.red   = rnd[`PS_COLOR_W-1:0];
      rnd     = $random(seed);
      w.green = rnd[`PS_COLOR_W-1:0];
      rnd     = $random(seed);
      w.blue  = rnd[`PS_COLOR_W-1:0];
      w.last  = with_last && (i == len - 1);
      write_pixel(w, 1'b1);
    end
  endtask

  function automatic int random_len(input int max_len);
    logic [31:0] rnd;
    rnd = $random(seed);
    return 1 + int'(rnd[15:0]) % max_len;
  endfunction

  // Every accepted pixel out and the reader idle
  task automatic wait_drained(input bit toggle_sink);
    int          cnt;
    logic [31:0] rnd;
    cnt = 0;
    while ((model_q.size() != 0 || o_busy) && cnt < TIMEOUT) begin
      if (toggle_sink) begin
        rnd = $random(seed);
        i_sink_en = rnd[0];
      end
      @(negedge clk);
      cnt++;
    end
    i_sink_en = 1'b1;
    if (model_q.size() != 0 || o_busy) begin
      show_error("timeout waiting for the buffer to drain");
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %-8s ok", name);
    end else begin
      $display("test %-8s %0d errors", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    int        errs;
    pix_word_t extra;
    seed       = 4042;
    rst        = 1'b1;
    i_wr_stb   = 1'b0;
    i_wr_last  = 1'b0;
    i_wr_red   = '0;
    i_wr_green = '0;
    i_wr_blue  = '0;
    i_sink_en  = 1'b0;
    {i_tp_red, i_tp_green, i_tp_blue} = 3'b000;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    errs = err_cnt;
    assert (!o_pixel_vld) else show_mismatch("o_pixel_vld", int'(o_pixel_vld), 0);
    assert (!o_busy) else show_mismatch("o_busy", int'(o_busy), 0);
    assert (!o_last) else show_mismatch("o_last", int'(o_last), 0);
    assert (!o_wr_full) else show_mismatch("o_wr_full", int'(o_wr_full), 0);
    assert (o_red == '0) else show_mismatch("o_red", int'(o_red), 0);
    assert (o_green == '0) else show_mismatch("o_green", int'(o_green), 0);
    assert (o_blue == '0) else show_mismatch("o_blue", int'(o_blue), 0);
    end_test("reset", errs);

    errs = err_cnt;
    i_sink_en = 1'b1;
    for (int b = 0; b < 6; b++) begin
      write_block(random_len(12), 1'b1);
    end
    wait_drained(1'b0);
    end_test("order", errs);

    errs = err_cnt;
    for (int p = 1; p < 8; p++) begin
      {i_tp_red, i_tp_green, i_tp_blue} = p[2:0];
      write_block(random_len(6), 1'b1);
      wait_drained(1'b0);
    end
    {i_tp_red, i_tp_green, i_tp_blue} = 3'b000;
    end_test("pattern", errs);

    errs = err_cnt;
    i_sink_en = 1'b0;
    for (int b = 0; b < 3; b++) begin
      write_block(random_len(12), 1'b1);
    end
    repeat (20) @(negedge clk);
    wait_drained(1'b1);
    end_test("pacing", errs);

    errs = err_cnt;
    write_block(5, 1'b0);
    for (int i = 0; i < 10 * `PS_PIX_DIV; i++) begin
      assert (!o_pixel_vld) else show_mismatch("o_pixel_vld", int'(o_pixel_vld), 0);
      assert (!o_busy) else show_mismatch("o_busy", int'(o_busy), 0);
      @(negedge clk);
    end
    write_block(1, 1'b1);
    wait_drained(1'b0);
    end_test("commit", errs);

    errs = err_cnt;
    i_sink_en = 1'b0;
    for (int b = 0; b < 4; b++) begin
      write_block(`PS_BUF_DEPTH / 4, 1'b1);
    end
    assert (o_wr_full) else show_mismatch("o_wr_full", int'(o_wr_full), 1);
    // Dropped words; any of them at the output is an unmatched pixel
    extra = '1;
    for (int i = 0; i < 4; i++) begin
      write_pixel(extra, 1'b0);
    end
    i_sink_en = 1'b1;
    wait_drained(1'b0);
    repeat (10 * `PS_PIX_DIV) @(negedge clk);
    end_test("full", errs);

    $display("tests %0d, pixels %0d, errors %0d", test_cnt, pix_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
